// ==== clock_pkg.sv ====
// ----------------------------------------
// widths, limits and encodings shared by the
// six-digit clock. time values are binary,
// 0 to 59 in a 6-bit unit
// segment patterns are a..g, high means lit
// ----------------------------------------
package clock_pkg;

	typedef logic [5:0] unit_t;		// one hour, minute or second value
	typedef logic [3:0] digit_t;	// one decimal digit
	typedef logic [6:0] seg_t;		// {a, b, c, d, e, f, g}
	typedef logic [5:0] digit_en_t;	// active low, bit 0 rightmost

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_t;

	localparam unit_t SEC_MAX    = 6'd59;
	localparam unit_t MIN_MAX    = 6'd59;
	localparam unit_t HOUR_MAX   = 6'd23;
	localparam int    NUM_DIGITS = 6;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// wrapping increment, no carry out
	function automatic unit_t unit_inc(input unit_t v, input unit_t max);
		unit_t nxt;
		nxt = (v >= max) ? '0 : unit_t'(v + 6'd1);
		return nxt;
	endfunction

	function automatic seg_t seg_decode(input digit_t d);
		seg_t s;
		case (d)
			4'd0:    s = 7'b111_1110;
			4'd1:    s = 7'b011_0000;
			4'd2:    s = 7'b110_1101;
			4'd3:    s = 7'b111_1001;
			4'd4:    s = 7'b011_0011;
			4'd5:    s = 7'b101_1011;
			4'd6:    s = 7'b101_1111;
			4'd7:    s = 7'b111_0000;
			4'd8:    s = 7'b111_1111;
			4'd9:    s = 7'b111_0011;
			default: s = SEG_BLANK;	// 10..15 stay dark
		endcase
		return s;
	endfunction

endpackage

// ==== tick_gen.sv ====
// ----------------------------------------
// one-cycle strobe every DIV clocks
// first strobe DIV cycles after reset release
// DIV must be at least 2
// ----------------------------------------
`timescale 1ns/100ps

module tick_gen #(
	parameter int DIV = 64
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt == CW'(DIV - 1));
			if (cnt == CW'(DIV - 1)) begin
				cnt <= '0;			// period wrap
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// ==== button_sync.sv ====
// ----------------------------------------
// samples the four buttons once per i_sample
// strobe and flags rising edges
// buttons are active high and asynchronous;
// a press is reported up to two sample
// periods after it starts
// ----------------------------------------
`timescale 1ns/100ps

module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_btn_mode,
	input  logic i_btn_field,
	input  logic i_btn_inc,
	input  logic i_btn_alarm,
	output logic o_press_mode,
	output logic o_press_field,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] btn;
	logic [3:0] samp_new;	// latest sample
	logic [3:0] samp_old;	// sample before that
	logic [3:0] press;

	assign btn = {i_btn_alarm, i_btn_inc, i_btn_field, i_btn_mode};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_new <= '0;
			samp_old <= '0;
		end else if (i_sample) begin
			samp_new <= btn;
			samp_old <= samp_new;
		end
	end

	// rising edge between the last two samples, one clk wide
	assign press = {4{i_sample}} & samp_new & ~samp_old;

	assign o_press_mode  = press[0];
	assign o_press_field = press[1];
	assign o_press_inc   = press[2];
	assign o_press_alarm = press[3];

endmodule

// ==== mode_ctrl.sv ====
// ----------------------------------------
// mode, selected field and alarm enable
// increment presses go to the time in setup
// mode and to the alarm in alarm mode; they
// are dropped in clock mode
// ----------------------------------------
`timescale 1ns/100ps

module mode_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_press_mode,
	input  logic              i_press_field,
	input  logic              i_press_inc,
	input  logic              i_press_alarm,
	output clock_pkg::mode_t  o_mode,
	output clock_pkg::field_t o_field,
	output logic              o_alarm_en,
	output logic              o_time_inc,
	output logic              o_alarm_inc,
	output logic              o_time_run
);

	import clock_pkg::*;

	mode_t  mode_q;
	field_t field_q;
	logic   alarm_en_q;

	// ----------------------------------------
	// mode FSM: clock -> setup -> alarm -> clock
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (mode_q)
				MODE_CLOCK: mode_q <= MODE_SETUP;
				MODE_SETUP: mode_q <= MODE_ALARM;
				default:    mode_q <= MODE_CLOCK;
			endcase
		end
	end

	// field select: sec -> min -> hour -> sec
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field_q <= FIELD_SEC;
		end else if (i_press_field) begin
			case (field_q)
				FIELD_SEC: field_q <= FIELD_MIN;
				FIELD_MIN: field_q <= FIELD_HOUR;
				default:   field_q <= FIELD_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_en_q <= 1'b0;
		end else if (i_press_alarm) begin
			alarm_en_q <= ~alarm_en_q;	// toggle
		end
	end

	assign o_mode      = mode_q;
	assign o_field     = field_q;
	assign o_alarm_en  = alarm_en_q;
	assign o_time_inc  = i_press_inc && (mode_q == MODE_SETUP);
	assign o_alarm_inc = i_press_inc && (mode_q == MODE_ALARM);
	assign o_time_run  = (mode_q != MODE_SETUP);	// time frozen while setting

endmodule

// ==== time_keeper.sv ====
// ----------------------------------------
// 24-hour time counters
// i_sec_tick advances seconds with carry when
// i_run is high; i_inc bumps only the
// selected field and never carries
// ----------------------------------------
`timescale 1ns/100ps

module time_keeper (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_tick,
	input  logic              i_run,
	input  logic              i_inc,
	input  clock_pkg::field_t i_field,
	output clock_pkg::unit_t  o_hour,
	output clock_pkg::unit_t  o_min,
	output clock_pkg::unit_t  o_sec
);

	import clock_pkg::*;

	unit_t hour_q;
	unit_t min_q;
	unit_t sec_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hour_q <= '0;
			min_q  <= '0;
			sec_q  <= '0;
		end else if (i_inc) begin
			case (i_field)
				FIELD_SEC:  sec_q  <= unit_inc(sec_q, SEC_MAX);
				FIELD_MIN:  min_q  <= unit_inc(min_q, MIN_MAX);
				FIELD_HOUR: hour_q <= unit_inc(hour_q, HOUR_MAX);
				default: ;
			endcase
		end else if (i_sec_tick && i_run) begin
			sec_q <= unit_inc(sec_q, SEC_MAX);
			if (sec_q == SEC_MAX) begin				// carry into minutes
				min_q <= unit_inc(min_q, MIN_MAX);
				if (min_q == MIN_MAX) begin			// and into hours
					hour_q <= unit_inc(hour_q, HOUR_MAX);
				end
			end
		end
	end

	assign o_hour = hour_q;
	assign o_min  = min_q;
	assign o_sec  = sec_q;

endmodule

// ==== alarm_unit.sv ====
// ----------------------------------------
// settable alarm time and alarm latch
// o_alarm sets one cycle after the time
// matches while i_en is high, and holds
// until i_en drops
// ----------------------------------------
`timescale 1ns/100ps

module alarm_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_inc,
	input  clock_pkg::field_t i_field,
	input  logic              i_en,
	input  clock_pkg::unit_t  i_hour,
	input  clock_pkg::unit_t  i_min,
	input  clock_pkg::unit_t  i_sec,
	output clock_pkg::unit_t  o_al_hour,
	output clock_pkg::unit_t  o_al_min,
	output clock_pkg::unit_t  o_al_sec,
	output logic              o_alarm
);

	import clock_pkg::*;

	unit_t al_hour_q;
	unit_t al_min_q;
	unit_t al_sec_q;
	logic  match;
	logic  alarm_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_hour_q <= '0;
			al_min_q  <= '0;
			al_sec_q  <= '0;
		end else if (i_inc) begin
			case (i_field)
				FIELD_SEC:  al_sec_q  <= unit_inc(al_sec_q, SEC_MAX);
				FIELD_MIN:  al_min_q  <= unit_inc(al_min_q, MIN_MAX);
				FIELD_HOUR: al_hour_q <= unit_inc(al_hour_q, HOUR_MAX);
				default: ;
			endcase
		end
	end

	assign match = (i_hour == al_hour_q) && (i_min == al_min_q) && (i_sec == al_sec_q);

	// latch the match, cleared by the enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else begin
			alarm_q <= i_en && (match || alarm_q);
		end
	end

	assign o_al_hour = al_hour_q;
	assign o_al_min  = al_min_q;
	assign o_al_sec  = al_sec_q;
	assign o_alarm   = alarm_q;

endmodule

// ==== display_scan.sv ====
// ----------------------------------------
// six-digit common-node scan
// one digit per i_scan_tick, digit 0 first
// in setup and alarm modes the selected field
// blinks and its ones digit shows the point
// segment and point outputs are active high
// ----------------------------------------
`timescale 1ns/100ps

module display_scan (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_scan_tick,
	input  logic                 i_sec_tick,
	input  clock_pkg::mode_t     i_mode,
	input  clock_pkg::field_t    i_field,
	input  clock_pkg::unit_t     i_hour,
	input  clock_pkg::unit_t     i_min,
	input  clock_pkg::unit_t     i_sec,
	input  clock_pkg::unit_t     i_al_hour,
	input  clock_pkg::unit_t     i_al_min,
	input  clock_pkg::unit_t     i_al_sec,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb
);

	import clock_pkg::*;

	logic [2:0] scan_idx;
	logic       blink_q;
	logic       edit_mode;
	logic       sel_field;	// current digit belongs to the selected field
	logic       blank;
	unit_t      show_hour;
	unit_t      show_min;
	unit_t      show_sec;
	digit_t     digits [NUM_DIGITS];

	// ----------------------------------------
	// scan index and blink phase
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == 3'(NUM_DIGITS - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_q <= 1'b0;
		end else if (i_sec_tick) begin
			blink_q <= ~blink_q;
		end
	end

	// ----------------------------------------
	// source select and digit split
	// ----------------------------------------
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			show_hour = i_al_hour;
			show_min  = i_al_min;
			show_sec  = i_al_sec;
		end else begin
			show_hour = i_hour;
			show_min  = i_min;
			show_sec  = i_sec;
		end
		digits[0] = digit_t'(show_sec % 6'd10);
		digits[1] = digit_t'(show_sec / 6'd10);
		digits[2] = digit_t'(show_min % 6'd10);
		digits[3] = digit_t'(show_min / 6'd10);
		digits[4] = digit_t'(show_hour % 6'd10);
		digits[5] = digit_t'(show_hour / 6'd10);
	end

	// ----------------------------------------
	// digit drive
	// ----------------------------------------
	assign edit_mode = (i_mode == MODE_SETUP) || (i_mode == MODE_ALARM);
	assign sel_field = (scan_idx[2:1] == i_field);	// digits 2k and 2k+1 form field k
	assign blank     = edit_mode && blink_q && sel_field;

	always_comb begin
		if (scan_idx < 3'(NUM_DIGITS)) begin
			o_seg = seg_decode(digits[scan_idx]);
		end else begin
			o_seg = SEG_BLANK;
		end
		if (blank) begin
			o_seg_enb = '1;			// whole digit dark
		end else begin
			o_seg_enb = ~(digit_en_t'(1) << scan_idx);
		end
		o_seg_dp = edit_mode && sel_field && !scan_idx[0];	// ones digit only
	end

endmodule

// ==== digital_clock_top.sv ====
// ----------------------------------------
// six-digit clock with alarm
// CLK_PER_SEC sets the seconds rate, which
// also drives the blink; CLK_PER_SCAN is the
// time per digit, CLK_PER_DEBOUNCE the button
// sample period. all must be at least 2
// ----------------------------------------
`timescale 1ns/100ps

module digital_clock_top #(
	parameter int CLK_PER_SEC      = 50_000_000,
	parameter int CLK_PER_SCAN     = 5_000,
	parameter int CLK_PER_DEBOUNCE = 500_000
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_btn_mode,
	input  logic                 i_btn_field,
	input  logic                 i_btn_inc,
	input  logic                 i_btn_alarm,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb,
	output logic                 o_alarm
);

	import clock_pkg::*;

	logic   sec_tick, scan_tick, db_tick;
	logic   press_mode, press_field, press_inc, press_alarm;
	mode_t  mode;
	field_t field;
	logic   alarm_en, time_inc, alarm_inc, time_run;
	unit_t  hour, min, sec;
	unit_t  al_hour, al_min, al_sec;

	// ----------------------------------------
	// strobes
	// ----------------------------------------
	tick_gen #(.DIV(CLK_PER_SEC))      u_sec_tick  (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.DIV(CLK_PER_SCAN))     u_scan_tick (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.DIV(CLK_PER_DEBOUNCE)) u_db_tick   (.clk, .rst_n, .o_tick(db_tick));

	button_sync u_button_sync (
		.clk, .rst_n, .i_sample(db_tick),
		.i_btn_mode, .i_btn_field, .i_btn_inc, .i_btn_alarm,
		.o_press_mode(press_mode), .o_press_field(press_field),
		.o_press_inc(press_inc), .o_press_alarm(press_alarm)
	);

	mode_ctrl u_mode_ctrl (
		.clk, .rst_n,
		.i_press_mode(press_mode), .i_press_field(press_field),
		.i_press_inc(press_inc), .i_press_alarm(press_alarm),
		.o_mode(mode), .o_field(field), .o_alarm_en(alarm_en),
		.o_time_inc(time_inc), .o_alarm_inc(alarm_inc), .o_time_run(time_run)
	);

	time_keeper u_time_keeper (
		.clk, .rst_n, .i_sec_tick(sec_tick), .i_run(time_run),
		.i_inc(time_inc), .i_field(field),
		.o_hour(hour), .o_min(min), .o_sec(sec)
	);

	alarm_unit u_alarm_unit (
		.clk, .rst_n, .i_inc(alarm_inc), .i_field(field), .i_en(alarm_en),
		.i_hour(hour), .i_min(min), .i_sec(sec),
		.o_al_hour(al_hour), .o_al_min(al_min), .o_al_sec(al_sec), .o_alarm
	);

	display_scan u_display_scan (
		.clk, .rst_n, .i_scan_tick(scan_tick), .i_sec_tick(sec_tick),
		.i_mode(mode), .i_field(field),
		.i_hour(hour), .i_min(min), .i_sec(sec),
		.i_al_hour(al_hour), .i_al_min(al_min), .i_al_sec(al_sec),
		.o_seg, .o_seg_dp, .o_seg_enb
	);

endmodule

// ==== digital_clock_assert.sv ====
// ----------------------------------------
// concurrent checks bound into the clock top
// uses internal nets of digital_clock_top
// whose names must stay as they are
// fail_count totals the failed checks
// ----------------------------------------
`timescale 1ns/100ps

module digital_clock_assert (
	input logic                 clk,
	input logic                 rst_n,
	input clock_pkg::digit_en_t i_seg_enb,
	input logic                 i_seg_dp,
	input logic                 i_alarm,
	input logic                 i_alarm_en,
	input clock_pkg::mode_t     i_mode,
	input logic                 i_time_inc,
	input logic                 i_alarm_inc
);

	import clock_pkg::*;

	int fail_count = 0;

	// at most one digit lit, and exactly one in clock mode where nothing blinks
	one_digit_on: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == MODE_CLOCK) ? $onehot(~i_seg_enb) : ($countones(~i_seg_enb) <= 1))
		else begin
			$error("digit enables do not select exactly one digit");
			fail_count++;
		end

	// alarm latch follows the enable one cycle later
	alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		!i_alarm_en |=> !i_alarm)
		else begin
			$error("alarm output high while the alarm is disabled");
			fail_count++;
		end

	no_dp_in_clock: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == MODE_CLOCK) |-> !i_seg_dp)
		else begin
			$error("decimal point lit in clock mode");
			fail_count++;
		end

	inc_one_target: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_time_inc && i_alarm_inc))
		else begin
			$error("time and alarm increments active together");
			fail_count++;
		end

endmodule

bind digital_clock_top digital_clock_assert u_clock_assert (
	.clk, .rst_n,
	.i_seg_enb(o_seg_enb), .i_seg_dp(o_seg_dp), .i_alarm(o_alarm),
	.i_alarm_en(alarm_en), .i_mode(mode),
	.i_time_inc(time_inc), .i_alarm_inc(alarm_inc)
);

// ==== tb_clk_gen.sv ====
// ----------------------------------------
// testbench clock and reset
// reset is low for RST_CYCLES clocks and is
// released on a falling edge
// ----------------------------------------
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== tb_digital_clock.sv ====
// ----------------------------------------
// testbench for the six-digit clock
// small dividers give 64 clocks per second
// with 2 per digit and 4 per button sample
// times are kept as seconds of the day
// ----------------------------------------
`timescale 1ns/100ps

module tb_digital_clock;

	localparam int SEC_CYC   = 64;
	localparam int DAY       = 86400;
	localparam int BTN_MODE  = 0;
	localparam int BTN_FIELD = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic       clk, rst_n;
	logic       btn_mode, btn_field, btn_inc, btn_alarm;
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	int cyc;			// posedges since reset release
	int errors, tests_run, tests_failed;
	int assert_fails;	// bound assertion failures already counted
	int base_secs, base_tick;	// model time and the tick index it was valid at

	tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(16)) u_clk_gen (.clk, .rst_n);

	digital_clock_top #(
		.CLK_PER_SEC(SEC_CYC), .CLK_PER_SCAN(2), .CLK_PER_DEBOUNCE(4)
	) digital_clock_top_inst (
		.clk, .rst_n,
		.i_btn_mode(btn_mode), .i_btn_field(btn_field),
		.i_btn_inc(btn_inc), .i_btn_alarm(btn_alarm),
		.o_seg(seg), .o_seg_dp(seg_dp), .o_seg_enb(seg_enb), .o_alarm(alarm)
	);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// ----------------------------------------
	// time model
	// ----------------------------------------
	function automatic int hms(input int h, input int m, input int s);
		return h * 3600 + m * 60 + s;
	endfunction

	function automatic string hms_str(input int t);
		return $sformatf("%02d:%02d:%02d", t / 3600, (t / 60) % 60, t % 60);
	endfunction

	function automatic int tick_index();
		return (cyc - 1) / SEC_CYC;	// value after the update edge of tick k
	endfunction

	function automatic int expected_now();
		return (base_secs + tick_index() - base_tick) % DAY;
	endfunction

	function automatic int steps(input int from, input int to, input int modulus);
		return (to - from + modulus) % modulus;
	endfunction

	// segments a..g back to a digit or 15 when unknown
	function automatic int seg_to_digit(input logic [6:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 15;
		endcase
	endfunction

	// ----------------------------------------
	// checks and waits
	// ----------------------------------------
	task automatic check_time(input string name, input int exp_t, input int act_t);
		assert (exp_t == act_t) else begin
			$display("Fail %s: expected %s actual %s", name, hms_str(exp_t), hms_str(act_t));
			errors++;
		end
	endtask

	task automatic check_value(input string name, input int exp_v, input int act_v);
		assert (exp_v == act_v) else begin
			$display("Fail %s: expected 0x%0h actual 0x%0h", name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timed out while waiting for %s", what);
		errors++;
	endtask

	task automatic wait_cycle(input int target);
		int guard;
		guard = 0;
		while (cyc < target && guard < 100000) begin
			@(negedge clk);
			guard++;
		end
		if (cyc < target) note_timeout("a cycle count");
	endtask

	task automatic wait_phase(input int offset);
		int guard;
		guard = 0;
		while (cyc % SEC_CYC != offset && guard < 2 * SEC_CYC) begin
			@(negedge clk);
			guard++;
		end
		if (cyc % SEC_CYC != offset) note_timeout("a point within the second");
	endtask

	task automatic set_button(input int which, input logic level);
		case (which)
			BTN_MODE:  btn_mode  = level;
			BTN_FIELD: btn_field = level;
			BTN_INC:   btn_inc   = level;
			default:   btn_alarm = level;
		endcase
	endtask

	// starts and ends on a falling edge
	task automatic push_button(input int which, input int times);
		repeat (times) begin
			set_button(which, 1'b1);
			repeat (16) @(negedge clk);
			set_button(which, 1'b0);
			repeat (16) @(negedge clk);
		end
	endtask

	// one pass until every digit was seen lit
	task automatic scan_once(output int t, output logic [5:0] dp_mask, output bit ok);
		int         digit [6];
		logic [5:0] seen;
		int         guard;
		int         idx;
		seen    = '0;
		dp_mask = '0;
		guard   = 0;
		idx     = 0;
		for (int i = 0; i < 6; i++) digit[i] = 0;
		while (seen != 6'h3f && guard < 4 * SEC_CYC) begin	// spans both blink phases
			@(negedge clk);
			guard++;
			if ($countones(~seg_enb) == 1) begin
				for (int i = 0; i < 6; i++) begin
					if (!seg_enb[i]) idx = i;
				end
				digit[idx] = seg_to_digit(seg);
				seen[idx]  = 1'b1;
				if (seg_dp) dp_mask[idx] = 1'b1;
			end
		end
		ok = (seen == 6'h3f);
		t  = hms(digit[5] * 10 + digit[4], digit[3] * 10 + digit[2], digit[1] * 10 + digit[0]);
	endtask

	// repeats the scan until two passes agree
	task automatic read_display(input string name, output int t, output logic [5:0] dp_mask);
		int         prev;
		logic [5:0] dp_b;
		bit         ok;
		bit         stable;
		int         tries;
		stable = 1'b0;
		tries  = 0;
		scan_once(prev, dp_mask, ok);
		t = prev;
		while (ok && !stable && tries < 4) begin
			scan_once(t, dp_b, ok);
			dp_mask |= dp_b;
			stable = (t == prev);
			prev   = t;
			tries++;
		end
		if (!(ok && stable)) begin
			$display("%s: display could not be read back", name);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		int fails_now;
		fails_now = digital_clock_top_inst.u_clock_assert.fail_count;
		if (fails_now != assert_fails) begin
			$display("bound assertions failed %0d times during %s",
				fails_now - assert_fails, name);
			errors += fails_now - assert_fails;
			assert_fails = fails_now;
		end
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed", name);
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		int         t, exp_t, errs0, guard, al_t;
		logic [5:0] dp;
		btn_mode     = 1'b0;
		btn_field    = 1'b0;
		btn_inc      = 1'b0;
		btn_alarm    = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		assert_fails = 0;
		base_secs    = 0;
		base_tick    = 0;
		guard        = 0;
		while (rst_n !== 1'b1 && guard < 100) begin
			@(negedge clk);
			guard++;
		end
		if (rst_n !== 1'b1) note_timeout("reset release");

		// reset state
		errs0 = errors;
		read_display("reset", t, dp);
		check_time("reset time", 0, t);
		check_value("reset dp", 0, dp);
		check_value("reset alarm", 0, alarm);
		end_test("reset", errs0);

		// carry from seconds into minutes read mid-second
		errs0 = errors;
		wait_cycle(61 * SEC_CYC + 16);
		read_display("carry", t, dp);
		check_time("carry", (base_secs + 61) % DAY, t);
		end_test("carry", errs0);

		// setup mode freezes the time while fields are set
		errs0 = errors;
		wait_cycle(62 * SEC_CYC + 16);
		exp_t = expected_now();
		push_button(BTN_MODE, 1);
		read_display("setup", t, dp);
		check_time("setup freeze", exp_t, t);
		check_value("setup dp sec", 6'b000001, dp);
		push_button(BTN_INC, steps(exp_t % 60, 58, 60));
		push_button(BTN_FIELD, 1);
		push_button(BTN_INC, steps((exp_t / 60) % 60, 59, 60));
		push_button(BTN_FIELD, 1);
		push_button(BTN_INC, steps(exp_t / 3600, 23, 24));
		read_display("setup", t, dp);
		check_time("setup hold", hms(23, 59, 58), t);
		check_value("setup dp hour", 6'b010000, dp);
		wait_phase(16);
		push_button(BTN_MODE, 1);		// into alarm mode where the time runs again
		base_secs = hms(23, 59, 58);
		base_tick = tick_index();
		push_button(BTN_MODE, 1);		// alarm -> clock
		wait_cycle((base_tick + 2) * SEC_CYC + 16);
		read_display("rollover", t, dp);
		check_time("day rollover", (base_secs + 2) % DAY, t);
		end_test("setup", errs0);

		// alarm setting where seconds wrap without carry
		errs0 = errors;
		wait_phase(16);
		push_button(BTN_MODE, 2);		// through setup without crossing a tick
		read_display("alarm", t, dp);
		check_time("alarm start", 0, t);
		push_button(BTN_FIELD, 1);		// hour -> sec
		push_button(BTN_INC, 59);
		read_display("alarm", t, dp);
		check_time("alarm sec 59", hms(0, 0, 59), t);
		push_button(BTN_INC, 1);
		read_display("alarm", t, dp);
		check_time("alarm sec wrap", 0, t);
		push_button(BTN_FIELD, 1);		// sec -> min
		push_button(BTN_INC, 1);
		al_t = hms(0, 1, 0);
		read_display("alarm", t, dp);
		check_time("alarm min", al_t, t);
		push_button(BTN_MODE, 1);		// alarm -> clock
		wait_phase(16);
		exp_t = expected_now();
		read_display("clock after alarm", t, dp);
		check_time("clock kept", exp_t, t);
		end_test("alarm_set", errs0);

		// alarm fires at the match and holds until disabled
		errs0 = errors;
		check_value("alarm idle", 0, alarm);
		push_button(BTN_ALARM, 1);
		guard = 0;
		while (!alarm && guard < 40 * SEC_CYC) begin
			@(negedge clk);
			guard++;
		end
		if (!alarm) begin
			note_timeout("the alarm output");
		end else begin
			check_time("alarm match", al_t, expected_now());
			read_display("alarm match", t, dp);
			check_time("alarm display", al_t, t);
			wait_cycle(cyc + 2 * SEC_CYC);
			check_value("alarm holds", 1, alarm);
			push_button(BTN_ALARM, 1);
			check_value("alarm cleared", 0, alarm);
		end
		end_test("alarm_fire", errs0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
clock_pkg.sv
tick_gen.sv
button_sync.sv
mode_ctrl.sv
time_keeper.sv
alarm_unit.sv
display_scan.sv
digital_clock_top.sv
digital_clock_assert.sv
tb_clk_gen.sv
tb_digital_clock.sv

// ==== Makefile ====
# Verilator build and run for the digital clock testbench

TOP = tb_digital_clock

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# fails on a nonzero exit or when the log holds the fail message
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	test $$rc -eq 0 && ! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log
